// ==== logic/fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// fraction width counts the hidden one.
// The multiplier also runs one iteration per fraction bit.
`define FPU_FRAC_W 24
`define FPU_EXP_W 8
`define FPU_BIAS 127

// extra high bits on the working fraction for carry and product growth.
`define FPU_GUARD_W 2

// word addresses of the bus registers.
`define FPU_ADR_OPA 3'd0
`define FPU_ADR_OPB 3'd1
`define FPU_ADR_CTRL 3'd2
`define FPU_ADR_STATUS 3'd3
`define FPU_ADR_RESULT 3'd4

`endif

// ==== logic/fpuPkg.sv ====
`default_nettype none

`include "fpu_macros.svh"

package fpuPkg;

    // working fraction: guard bits on top of the fraction with its hidden one.
    localparam int WorkW = `FPU_GUARD_W + `FPU_FRAC_W;

    // two spare bits so exponent sums and adjustments stay signed.
    localparam int ExpW = `FPU_EXP_W + 2;

    // a float split into fields, exponent still biased.
    typedef struct packed {
        logic                   sign;
        logic                   zero;
        logic signed [ExpW-1:0] exponent;
        logic [WorkW-1:0]       fraction;
    } floatParts;

    typedef enum logic [1:0] {
        opAdd = 2'd0,
        opSub = 2'd1,
        opMul = 2'd2
    } fpuOp;

    typedef enum logic [2:0] {
        stIdle,
        stAddSub,
        stMul,
        stNorm,
        stDone
    } coreState;

endpackage

`default_nettype wire

// ==== logic/wbPkg.sv ====
`default_nettype none

`include "fpu_macros.svh"

package wbPkg;

    // master to slave, held stable until ack.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] datW;
    } wbReq;

    typedef struct packed {
        logic        ack;
        logic [31:0] datR;
    } wbRsp;

    typedef enum logic [2:0] {
        adrOpA    = `FPU_ADR_OPA,
        adrOpB    = `FPU_ADR_OPB,
        adrCtrl   = `FPU_ADR_CTRL,
        adrStatus = `FPU_ADR_STATUS,
        adrResult = `FPU_ADR_RESULT
    } regAdr;

endpackage

`default_nettype wire

// ==== logic/floatAddSub.sv ====
`timescale 1ns/10ps
`default_nettype none

module floatAddSub (
    input  wire                      clk,
    input  wire                      arstN,
    input  wire                      start,
    input  wire                      sub,
    input  wire fpuPkg::floatParts   a,
    input  wire fpuPkg::floatParts   b,
    output logic                     valid,
    output fpuPkg::floatParts        sum
);

    fpuPkg::floatParts           bEff;
    fpuPkg::floatParts           big;
    fpuPkg::floatParts           lesser;
    logic [fpuPkg::ExpW-1:0]     expDiff;
    fpuPkg::floatParts           s1Big;
    logic [fpuPkg::WorkW-1:0]    s1SmallFrac;
    logic                        s1EffSub;
    logic                        s1Valid;
    logic [fpuPkg::WorkW-1:0]    magnitude;

    // subtraction is addition of b with its sign flipped.
    // The larger magnitude leads so the difference never goes negative.
    always_comb begin
        bEff      = b;
        bEff.sign = b.sign ^ sub;
        if (a.zero) begin
            big    = bEff;
            lesser = a;
        end else if (b.zero) begin
            big    = a;
            lesser = bEff;
        end else if ((a.exponent > b.exponent) ||
                     ((a.exponent == b.exponent) && (a.fraction >= b.fraction))) begin
            big    = a;
            lesser = bEff;
        end else begin
            big    = bEff;
            lesser = a;
        end
        expDiff = big.exponent - lesser.exponent;
    end

    assign magnitude = s1EffSub ? (s1Big.fraction - s1SmallFrac)
                                : (s1Big.fraction + s1SmallFrac);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            valid   <= 1'b0;
        end else begin
            s1Valid <= start;
            valid   <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1Big       <= big;
            // shifted-out bits are simply dropped.
            s1SmallFrac <= lesser.zero ? '0 : (lesser.fraction >> expDiff);
            s1EffSub    <= big.sign ^ lesser.sign;
        end
        if (s1Valid) begin
            sum.sign     <= s1Big.sign;
            sum.exponent <= s1Big.exponent;
            sum.fraction <= magnitude;
            sum.zero     <= (magnitude == '0);
        end
    end

endmodule

`default_nettype wire

// ==== logic/floatMul.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fpu_macros.svh"

module floatMul (
    input  wire                      clk,
    input  wire                      arstN,
    input  wire                      start,
    input  wire fpuPkg::floatParts   a,
    input  wire fpuPkg::floatParts   b,
    output logic                     valid,
    output fpuPkg::floatParts        prod
);

    localparam int FracW = `FPU_FRAC_W;
    localparam int CntW = $clog2(FracW);
    localparam logic [CntW-1:0] LastCount = CntW'(FracW - 1);

    logic                           running;
    logic [CntW-1:0]                count;
    logic [FracW-1:0]               mcand;
    logic [2*FracW-1:0]             acc;
    logic [FracW:0]                 partial;
    logic                           sign;
    logic                           zero;
    logic signed [fpuPkg::ExpW-1:0] exponent;

    // the low half of acc starts as the multiplier and is consumed one bit per step.
    assign partial = {1'b0, acc[2*FracW-1:FracW]} + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
            count   <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (running) begin
                count <= count + 1'b1;
                if (count == LastCount) begin
                    running <= 1'b0;
                    valid   <= 1'b1;
                end
            end else if (start) begin
                running <= 1'b1;
                count   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            acc <= {partial, acc[FracW-1:1]};
        end else if (start) begin
            mcand    <= a.fraction[FracW-1:0];
            acc      <= {{FracW{1'b0}}, b.fraction[FracW-1:0]};
            sign     <= a.sign ^ b.sign;
            zero     <= a.zero | b.zero;
            // one less, since the kept bits sit one place above the hidden-one position.
            exponent <= a.exponent + b.exponent - `FPU_BIAS - 1;
        end
    end

    always_comb begin
        prod.sign     = zero ? 1'b0 : sign;
        prod.zero     = zero;
        prod.exponent = exponent;
        prod.fraction = acc[2*FracW-1 -: fpuPkg::WorkW];
    end

endmodule

`default_nettype wire

// ==== logic/floatNormalize.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fpu_macros.svh"

module floatNormalize (
    input  wire                      clk,
    input  wire                      arstN,
    input  wire                      inValid,
    input  wire fpuPkg::floatParts   in,
    output logic                     outValid,
    output logic [31:0]              word
);

    // bit position of the hidden one in a normalized working fraction.
    localparam int HidePos = `FPU_FRAC_W - 1;
    localparam int PosW = $clog2(fpuPkg::WorkW);

    logic [PosW-1:0]                lead;
    logic                           shiftLeft;
    logic [PosW-1:0]                shiftDist;
    logic [fpuPkg::WorkW-1:0]       fracShifted;
    logic signed [fpuPkg::ExpW-1:0] expAdj;
    logic                           isZero;

    always_comb begin
        // the highest set bit wins since later iterations overwrite.
        lead = '0;
        for (int i = 0; i < fpuPkg::WorkW; i++) begin
            if (in.fraction[i]) begin
                lead = PosW'(i);
            end
        end
        shiftLeft = (lead < HidePos);
        shiftDist = shiftLeft ? (PosW'(HidePos) - lead) : (lead - PosW'(HidePos));
        if (shiftLeft) begin
            fracShifted = in.fraction << shiftDist;
            expAdj      = in.exponent - shiftDist;
        end else begin
            fracShifted = in.fraction >> shiftDist;
            expAdj      = in.exponent + shiftDist;
        end
        isZero = in.zero || (in.fraction == '0);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            if (isZero) begin
                word <= '0;
            end else begin
                word <= {in.sign, expAdj[`FPU_EXP_W-1:0], fracShifted[HidePos-1:0]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fpuCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpuCore (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire                 start,
    input  wire fpuPkg::fpuOp   op,
    input  wire [31:0]          opA,
    input  wire [31:0]          opB,
    output logic                busy,
    output logic                done,
    output logic [31:0]         result
);

    fpuPkg::coreState  state;
    fpuPkg::fpuOp      opReg;
    fpuPkg::floatParts partsA;
    fpuPkg::floatParts partsB;
    fpuPkg::floatParts sum;
    fpuPkg::floatParts prod;
    fpuPkg::floatParts normIn;
    logic              addValid;
    logic              mulValid;
    logic              normInValid;
    logic              normValid;
    logic [31:0]       normWord;

    // an exponent field of zero is taken as zero, whatever the fraction holds.
    function automatic fpuPkg::floatParts unpack(input logic [31:0] w);
        fpuPkg::floatParts p;
        p.sign     = w[31];
        p.zero     = (w[30:23] == 8'd0);
        p.exponent = {2'b00, w[30:23]};
        p.fraction = p.zero ? '0 : {2'b00, 1'b1, w[22:0]};
        return p;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= fpuPkg::stIdle;
            opReg <= fpuPkg::opAdd;
        end else begin
            case (state)
                fpuPkg::stIdle: begin
                    if (start) begin
                        opReg <= op;
                        state <= (op == fpuPkg::opMul) ? fpuPkg::stMul : fpuPkg::stAddSub;
                    end
                end
                // launch states last one cycle and give the unit its start pulse.
                fpuPkg::stAddSub,
                fpuPkg::stMul: state <= fpuPkg::stNorm;
                fpuPkg::stNorm: begin
                    if (normInValid) begin
                        state <= fpuPkg::stDone;
                    end
                end
                default: state <= fpuPkg::stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == fpuPkg::stIdle) && start) begin
            partsA <= unpack(opA);
            partsB <= unpack(opB);
        end
    end

    assign normIn      = (opReg == fpuPkg::opMul) ? prod : sum;
    assign normInValid = (opReg == fpuPkg::opMul) ? mulValid : addValid;

    assign busy   = (state != fpuPkg::stIdle);
    assign done   = normValid;
    assign result = normWord;

    floatAddSub uAddSub (
        .clk   (clk),
        .arstN (arstN),
        .start (state == fpuPkg::stAddSub),
        .sub   (opReg == fpuPkg::opSub),
        .a     (partsA),
        .b     (partsB),
        .valid (addValid),
        .sum   (sum)
    );

    floatMul uMul (
        .clk   (clk),
        .arstN (arstN),
        .start (state == fpuPkg::stMul),
        .a     (partsA),
        .b     (partsB),
        .valid (mulValid),
        .prod  (prod)
    );

    floatNormalize uNorm (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (normInValid),
        .in       (normIn),
        .outValid (normValid),
        .word     (normWord)
    );

endmodule

`default_nettype wire

// ==== logic/wbFpuRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module wbFpuRegs (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire wbPkg::wbReq    req,
    output wbPkg::wbRsp         rsp,
    input  wire                 busy,
    input  wire                 done,
    input  wire [31:0]          result,
    output logic                start,
    output fpuPkg::fpuOp        op,
    output logic [31:0]         opA,
    output logic [31:0]         opB
);

    wbPkg::regAdr adr;
    logic         access;
    logic         ctrlWrite;
    logic         take;
    logic         ack;
    logic [31:0]  datR;
    logic [31:0]  resultReg;
    logic [31:0]  readData;

    assign adr = wbPkg::regAdr'(req.adr);

    // the master still holds stb in the ack cycle, so that cycle is not a new access.
    assign access    = req.cyc && req.stb && !ack;
    assign ctrlWrite = req.we && (adr == wbPkg::adrCtrl);

    // a control write waits while an operation is running or just being started.
    assign take = access && !(ctrlWrite && (busy || start));

    always_comb begin
        case (adr)
            wbPkg::adrOpA:    readData = opA;
            wbPkg::adrOpB:    readData = opB;
            wbPkg::adrCtrl:   readData = {30'b0, op};
            wbPkg::adrStatus: readData = {31'b0, busy || start};
            wbPkg::adrResult: readData = resultReg;
            default:          readData = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack       <= 1'b0;
            start     <= 1'b0;
            op        <= fpuPkg::opAdd;
            resultReg <= '0;
        end else begin
            ack   <= take;
            start <= take && ctrlWrite;
            if (take && ctrlWrite) begin
                op <= fpuPkg::fpuOp'(req.datW[1:0]);
            end
            if (done) begin
                resultReg <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && req.we) begin
            case (adr)
                wbPkg::adrOpA: opA <= req.datW;
                wbPkg::adrOpB: opB <= req.datW;
                default: ;
            endcase
        end
        if (take && !req.we) begin
            datR <= readData;
        end
    end

    always_comb begin
        rsp.ack  = ack;
        rsp.datR = datR;
    end

endmodule

`default_nettype wire

// ==== logic/fpuTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpuTop (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire wbPkg::wbReq    req,
    output wbPkg::wbRsp         rsp
);

    logic         start;
    logic         busy;
    logic         done;
    logic [31:0]  result;
    fpuPkg::fpuOp op;
    logic [31:0]  opA;
    logic [31:0]  opB;

    wbFpuRegs uRegs (
        .clk    (clk),
        .arstN  (arstN),
        .req    (req),
        .rsp    (rsp),
        .busy   (busy),
        .done   (done),
        .result (result),
        .start  (start),
        .op     (op),
        .opA    (opA),
        .opB    (opB)
    );

    fpuCore uCore (
        .clk    (clk),
        .arstN  (arstN),
        .start  (start),
        .op     (op),
        .opA    (opA),
        .opB    (opB),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

endmodule

`default_nettype wire

// ==== verif/fpuTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fpu_macros.svh"

module fpuTb;

    localparam int NumRows = 14;
    // the bus tests run three operations beyond the table.
    localparam int NumOps = NumRows + 3;
    // one bus cycle costs two clocks plus an idle gap of up to three.
    localparam int BusClocks = 5;
    localparam int TimeoutCycles = NumOps * (27 + 20 * BusClocks) + 200;

    logic        clk;
    logic        arstN;
    wbPkg::wbReq req;
    wbPkg::wbRsp rsp;

    integer      seed;
    int          cycleCount;
    int          waits;
    logic [31:0] readValue;

    string        rowName [NumRows];
    fpuPkg::fpuOp rowOp   [NumRows];
    logic [31:0]  rowA    [NumRows];
    logic [31:0]  rowB    [NumRows];
    logic [31:0]  rowExp  [NumRows];

    fpuTop u_dut (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .rsp   (rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", TimeoutCycles);
            $display("Done: errors found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic idleGap();
        int gap;
        gap = {$random(seed)} % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one Wishbone classic access, held until ack, then released.
    task automatic accessBus(input logic we, input logic [2:0] adr, input logic [31:0] datW,
                             output logic [31:0] datR, output int waitCycles);
        req.cyc    = 1'b1;
        req.stb    = 1'b1;
        req.we     = we;
        req.adr    = adr;
        req.datW   = datW;
        waitCycles = 0;
        @(posedge clk);
        #1;
        while (!rsp.ack) begin
            waitCycles = waitCycles + 1;
            @(posedge clk);
            #1;
        end
        datR    = rsp.datR;
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
        idleGap();
    endtask

    task automatic writeWord(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        int          stalls;
        accessBus(1'b1, adr, data, unused, stalls);
    endtask

    task automatic readWord(input logic [2:0] adr, output logic [31:0] data);
        int stalls;
        accessBus(1'b0, adr, 32'h0, data, stalls);
    endtask

    task automatic waitIdle();
        logic [31:0] status;
        readWord(`FPU_ADR_STATUS, status);
        while (status[0]) begin
            readWord(`FPU_ADR_STATUS, status);
        end
    endtask

    task automatic setRow(input int i, input string name, input fpuPkg::fpuOp op,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] expected);
        rowName[i] = name;
        rowOp[i]   = op;
        rowA[i]    = a;
        rowB[i]    = b;
        rowExp[i]  = expected;
    endtask

    task automatic runRow(input int i);
        logic [31:0] result;
        writeWord(`FPU_ADR_OPA, rowA[i]);
        writeWord(`FPU_ADR_OPB, rowB[i]);
        writeWord(`FPU_ADR_CTRL, {30'b0, rowOp[i]});
        waitIdle();
        readWord(`FPU_ADR_RESULT, result);
        checkValue(rowName[i], rowExp[i], result);
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        req        = '0;
        seed       = 85;
        cycleCount = 0;

        // expected words follow truncation toward zero with no rounding.
        setRow(0, "addExact", fpuPkg::opAdd, 32'h3FC00000, 32'h40100000, 32'h40700000);
        setRow(1, "subExact", fpuPkg::opSub, 32'h40A00000, 32'h3F800000, 32'h40800000);
        setRow(2, "subNegative", fpuPkg::opSub, 32'h3F800000, 32'h40400000, 32'hC0000000);
        setRow(3, "addTinyLost", fpuPkg::opAdd, 32'h3F800000, 32'h30800000, 32'h3F800000);
        setRow(4, "addHalfLost", fpuPkg::opAdd, 32'h4B7FFFFF, 32'h3F000000, 32'h4B7FFFFF);
        setRow(5, "addCarryOut", fpuPkg::opAdd, 32'h3FC00000, 32'h3FC00000, 32'h40400000);
        setRow(6, "subNearEqual", fpuPkg::opSub, 32'h3F800001, 32'h3F800000, 32'h34000000);
        setRow(7, "subCancel", fpuPkg::opSub, 32'h40490FDB, 32'h40490FDB, 32'h00000000);
        setRow(8, "mulNegative", fpuPkg::opMul, 32'h40400000, 32'hC0200000, 32'hC0F00000);
        setRow(9, "mulExact", fpuPkg::opMul, 32'h3FC00000, 32'h3FC00000, 32'h40100000);
        setRow(10, "mulTruncate", fpuPkg::opMul, 32'h3F800001, 32'h3F800001, 32'h3F800002);
        // a zero exponent field is zero even with fraction bits set.
        setRow(11, "mulZeroExpField", fpuPkg::opMul, 32'h00400000, 32'h40400000, 32'h0);
        setRow(12, "mulNegZero", fpuPkg::opMul, 32'hC0000000, 32'h80000000, 32'h0);
        setRow(13, "addZeroOperand", fpuPkg::opAdd, 32'h00000000, 32'h40400000, 32'h40400000);

        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;

        readWord(`FPU_ADR_RESULT, readValue);
        checkValue("resetResult", 32'h0, readValue);
        readWord(`FPU_ADR_STATUS, readValue);
        checkValue("resetStatus", 32'h0, readValue);

        writeWord(`FPU_ADR_OPA, 32'h12345678);
        writeWord(`FPU_ADR_OPB, 32'h9ABCDEF0);
        readWord(`FPU_ADR_OPA, readValue);
        checkValue("readbackOpA", 32'h12345678, readValue);
        readWord(`FPU_ADR_OPB, readValue);
        checkValue("readbackOpB", 32'h9ABCDEF0, readValue);

        for (int i = 0; i < NumRows; i++) begin
            runRow(i);
        end

        // status is busy right after a multiply starts and idle once it ends.
        writeWord(`FPU_ADR_OPA, 32'h40400000);
        writeWord(`FPU_ADR_OPB, 32'hC0200000);
        writeWord(`FPU_ADR_CTRL, {30'b0, fpuPkg::opMul});
        readWord(`FPU_ADR_STATUS, readValue);
        checkValue("statusBusy", 32'h1, readValue);
        waitIdle();
        readWord(`FPU_ADR_STATUS, readValue);
        checkValue("statusIdle", 32'h0, readValue);
        readWord(`FPU_ADR_RESULT, readValue);
        checkValue("mulResult", 32'hC0F00000, readValue);

        // the core already holds its operands, so new ones can be written mid-multiply.
        writeWord(`FPU_ADR_CTRL, {30'b0, fpuPkg::opMul});
        writeWord(`FPU_ADR_OPA, 32'h3FC00000);
        writeWord(`FPU_ADR_OPB, 32'h40100000);
        accessBus(1'b1, `FPU_ADR_CTRL, {30'b0, fpuPkg::opAdd}, readValue, waits);
        // a back-to-back access already sees one empty cycle while the previous ack clears.
        checkValue("ctrlHeldOff", 32'h1, {31'b0, waits > 1});
        waitIdle();
        readWord(`FPU_ADR_RESULT, readValue);
        checkValue("addAfterMul", 32'h40700000, readValue);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/fpuPkg.sv
logic/wbPkg.sv
logic/floatAddSub.sv
logic/floatMul.sv
logic/floatNormalize.sv
logic/fpuCore.sv
logic/wbFpuRegs.sv
logic/fpuTop.sv
verif/fpuTb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Compiles the FPU testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fpuSim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module fpuTb \
    -f flist.f \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build.sh: Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "build.sh: simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG_FILE"; then
    echo "build.sh: simulation passed"
    exit 0
else
    echo "build.sh: simulation failed, see $LOG_FILE"
    exit 1
fi
